//--- verilog/crop_defs.svh
// Widths, keyboard codes, crop steps and blank margins for the display crop logic
// Included by every RTL file of the crop design
`ifndef CROP_DEFS_SVH
`define CROP_DEFS_SVH

`define CROP_W        12       // Counters and crop edges

`define KBD_TYPE_KEY  2'd3     // Event carries a keyboard code

`define KEY_BKSP      8'h41
`define KEY_UP        8'h4c
`define KEY_DOWN      8'h4d
`define KEY_LEFT      8'h4f
`define KEY_RIGHT     8'h4e
`define KEY_ALT_L     8'h64
`define KEY_ALT_R     8'h65
`define KEY_ALT_L_UP  8'he4
`define KEY_ALT_R_UP  8'he5

`define H_STEP        12'd4    // Pixels per left/right press
`define V_STEP        12'd1    // Lines per up/down press
`define FHBL_START    12'd8    // Forced horizontal blank margin

`endif

//--- verilog/crop_pkg.sv
// Shared types of the display crop design
// Imported by every RTL module and by the testbench
`include "crop_defs.svh"

package crop_pkg;

	// Decoded keyboard command
	typedef enum logic [2:0] {
		op_none,
		op_clear,
		op_up,
		op_down,
		op_left,
		op_right,
		op_alt_on,
		op_alt_off
	} key_op_e;

	typedef struct packed {
		logic [7:0] data;   // Key code
		logic [1:0] kind;   // Keyboard code when 3
		logic       level;  // Toggles once per new event
	} kbd_event_t;

	// Crop edges in counter units
	typedef struct packed {
		logic [`CROP_W-1:0] vbl_t;
		logic [`CROP_W-1:0] vbl_b;  // Top bit set counts back from the last line
		logic [`CROP_W-1:0] hbl_l;
		logic [`CROP_W-1:0] hbl_r;
	} crop_t;

	typedef struct packed {
		logic       hs_n;
		logic       vs_n;
		logic       hblank;
		logic       vblank;
		logic [1:0] res;
	} video_in_t;

	typedef struct packed {
		logic               hbl;      // Forced, crop and sync blank combined
		logic               hs_fall;  // Line start strobe
		logic [`CROP_W-1:0] hsize;    // Active width
		logic [`CROP_W-1:0] hmax;     // Line length
	} line_meas_t;

	typedef struct packed {
		logic [`CROP_W-1:0] hsize;
		logic [`CROP_W-1:0] vsize;
		logic [1:0]         res;
		crop_t              crop;
	} screen_info_t;

endpackage

//--- verilog/kbd_crop_ctrl.sv
// Keyboard side of the crop logic
// Turns arrow, backspace and alt key events into crop edge updates
`timescale 1ns/100ps
`include "crop_defs.svh"

module kbd_crop_ctrl import crop_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  kbd_event_t kbd,
	output crop_t      crop
);

	logic    old_level;
	logic    alt;      // Arrows move the bottom and right edges while held
	logic    kbd_new;
	key_op_e op;

	// Level differs from last clock means a fresh event
	assign kbd_new = (old_level ^ kbd.level) && (kbd.kind == `KBD_TYPE_KEY);

	always_comb begin
		op = op_none;
		if (kbd_new) begin
			case (kbd.data)
				`KEY_BKSP:                   op = op_clear;
				`KEY_UP:                     op = op_up;
				`KEY_DOWN:                   op = op_down;
				`KEY_LEFT:                   op = op_left;
				`KEY_RIGHT:                  op = op_right;
				`KEY_ALT_L, `KEY_ALT_R:       op = op_alt_on;
				`KEY_ALT_L_UP, `KEY_ALT_R_UP: op = op_alt_off;
				default:                     op = op_none;
			endcase
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			alt       <= 1'b0;
			crop      <= '0;
		end else begin
			old_level <= kbd.level;
			case (op)
				op_clear: crop <= '0;
				op_up: begin
					if (alt) crop.vbl_b <= crop.vbl_b + `V_STEP;
					else     crop.vbl_t <= crop.vbl_t + `V_STEP;
				end
				op_down: begin
					if (alt) crop.vbl_b <= crop.vbl_b - `V_STEP;
					else     crop.vbl_t <= crop.vbl_t - `V_STEP;
				end
				op_left: begin
					if (alt) crop.hbl_r <= crop.hbl_r + `H_STEP;
					else     crop.hbl_l <= crop.hbl_l + `H_STEP;
				end
				op_right: begin
					if (alt) crop.hbl_r <= crop.hbl_r - `H_STEP;
					else     crop.hbl_l <= crop.hbl_l - `H_STEP;
				end
				op_alt_on:  alt <= 1'b1;
				op_alt_off: alt <= 1'b0;
				default: ;  // Unknown codes leave the edges alone
			endcase
		end
	end

endmodule

//--- verilog/line_timing.sv
// Horizontal side of the video measurement
// Counts clocks per line, records blank edges and builds the horizontal blank
`timescale 1ns/100ps
`include "crop_defs.svh"

module line_timing import crop_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  video_in_t  vid,
	input  crop_t      crop,
	input  logic       line_is_one,
	output line_meas_t line
);

	logic               old_hs_n;
	logic               old_hblank;
	logic [`CROP_W-1:0] hcnt;
	logic [`CROP_W-1:0] hend;   // Count at end of hblank
	logic [`CROP_W-1:0] hsta;   // Count at start of hblank
	logic [`CROP_W-1:0] hmax;   // Count at hsync fall
	logic [`CROP_W-1:0] hsize;
	logic               shbl;   // Crop blank
	logic               fhbl;   // Forced blank
	logic               hblank_rise;

	assign hblank_rise = ~old_hblank & vid.hblank;

	assign line = '{
		hbl:     fhbl | shbl | ~vid.hs_n,
		hs_fall: old_hs_n & ~vid.hs_n,
		hsize:   hsize,
		hmax:    hmax
	};

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs_n   <= 1'b0;
			old_hblank <= 1'b0;
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			hsize      <= '0;
			shbl       <= 1'b0;
			fhbl       <= 1'b0;
		end else begin
			old_hs_n   <= vid.hs_n;
			old_hblank <= vid.hblank;

			if (~vid.hs_n) hcnt <= '0;  // Held at zero through sync
			else           hcnt <= hcnt + 12'd1;

			if (old_hblank & ~vid.hblank) hend <= hcnt;
			if (hblank_rise)              hsta <= hcnt;
			if (old_hs_n & ~vid.hs_n)     hmax <= hcnt;

			// Crop edges move 2 counts early to line up with the registered hde
			if (hcnt == hend + crop.hbl_l - 12'd2) shbl <= 1'b0;
			if (hcnt == hsta + crop.hbl_r - 12'd2) shbl <= 1'b1;

			if (hcnt == `FHBL_START)        fhbl <= 1'b0;
			if (hcnt == hmax - `FHBL_START) fhbl <= 1'b1;

			if (hblank_rise & line_is_one) hsize <= hcnt - hend;  // Once per frame
		end
	end

endmodule

//--- verilog/frame_timing.sv
// Vertical side of the video measurement
// Counts lines, measures the active height and drives the display enables
// vblank_end marks the end of each vertical blank for the screen monitor
`timescale 1ns/100ps
`include "crop_defs.svh"

module frame_timing import crop_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  video_in_t          vid,
	input  crop_t              crop,
	input  line_meas_t         line,
	output logic               line_is_one,
	output logic               hde,
	output logic               vde,
	output logic               vblank_end,
	output logic [`CROP_W-1:0] vsize
);

	logic               vblank_full;  // vblank or vsync
	logic               old_vblank;
	logic               old_vs_n;
	logic               old_hbl;
	logic [`CROP_W-1:0] vcnt;
	logic [`CROP_W-1:0] vend;     // Line count at vblank end
	logic [`CROP_W-1:0] vmax;     // Line count at vblank start
	logic [`CROP_W-1:0] vs_end;   // Line count at vsync rise
	logic [`CROP_W-1:0] vbot;
	logic               svbl;     // Crop blank
	logic               fvbl;     // Forced blank
	logic               vblank_rise;
	logic               vblank_fall;

	assign vblank_full = vid.vblank | ~vid.vs_n;
	assign vblank_rise = ~old_vblank & vblank_full;
	assign vblank_fall = old_vblank & ~vblank_full;

	assign line_is_one = (vcnt == 12'd1);
	assign vde         = ~(fvbl | svbl);

	// Bottom edge counts from the top unless its top bit is set
	assign vbot = crop.vbl_b[`CROP_W-1] ? vmax + crop.vbl_b : crop.vbl_b;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vblank <= 1'b0;
			old_vs_n   <= 1'b0;
			old_hbl    <= 1'b0;
			vcnt       <= '0;
			vend       <= '0;
			vmax       <= '0;
			vs_end     <= '0;
			vsize      <= '0;
			svbl       <= 1'b0;
			fvbl       <= 1'b0;
			hde        <= 1'b0;
			vblank_end <= 1'b0;
		end else begin
			old_vblank <= vblank_full;
			old_vs_n   <= vid.vs_n;
			old_hbl    <= line.hbl;

			if (line.hs_fall) vcnt <= vcnt + 12'd1;
			if (vblank_rise)  vcnt <= '0;

			if (vblank_fall)              vend   <= vcnt;
			if (~old_vs_n & vid.vs_n)     vs_end <= vcnt;
			if (vblank_rise) begin
				vmax  <= vcnt;
				vsize <= vcnt - vend;
			end

			// Vertical flags only move at the start of active pixels
			if ((old_hbl & ~line.hbl) || (vcnt == '0)) begin
				if (vcnt == vend + crop.vbl_t) svbl <= 1'b0;
				if (vcnt == vbot)              svbl <= 1'b1;

				if (vcnt == vmax - 12'd1)   fvbl <= 1'b1;
				if (vcnt == vs_end + 12'd2) fvbl <= 1'b0;
			end

			hde        <= ~line.hbl;
			vblank_end <= vblank_fall;
		end
	end

endmodule

//--- verilog/screen_monitor.sv
// Screen geometry snapshot taken at the end of every vertical blank
// scr_flg counts frames whose geometry or resolution differs from the previous one
`timescale 1ns/100ps
`include "crop_defs.svh"

module screen_monitor import crop_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               vblank_end,
	input  logic [`CROP_W-1:0] hsize,
	input  logic [`CROP_W-1:0] vsize,
	input  logic [1:0]         res,
	input  crop_t              crop,
	output screen_info_t       scr,
	output logic [6:0]         scr_flg
);

	logic mode_changed;

	// Crop changes do not count as a mode change
	assign mode_changed = (scr.res != res) || (scr.hsize != hsize) ||
		(scr.vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			scr     <= '0;
			scr_flg <= '0;
		end else if (vblank_end) begin
			scr.hsize <= hsize;
			scr.vsize <= vsize;
			scr.res   <= res;
			scr.crop  <= crop;
			if (mode_changed) scr_flg <= scr_flg + 7'd1;  // Wraps at 128
		end
	end

endmodule

//--- verilog/video_crop_top.sv
// Top level of the adjustable display crop
// Keyboard events in, display enables and the screen snapshot out
`timescale 1ns/100ps
`include "crop_defs.svh"

module video_crop_top import crop_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  kbd_event_t   kbd,
	input  video_in_t    vid,
	output logic         hde,
	output logic         vde,
	output screen_info_t scr,
	output logic [6:0]   scr_flg
);

	crop_t              crop;
	line_meas_t         line;
	logic               line_is_one;
	logic               vblank_end;
	logic [`CROP_W-1:0] vsize;

	kbd_crop_ctrl u_kbd (
		.clk_sys (clk_sys),
		.reset   (reset),
		.kbd     (kbd),
		.crop    (crop)
	);

	line_timing u_line (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.vid         (vid),
		.crop        (crop),
		.line_is_one (line_is_one),  // From the line counter in u_frame
		.line        (line)
	);

	frame_timing u_frame (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.vid         (vid),
		.crop        (crop),
		.line        (line),
		.line_is_one (line_is_one),
		.hde         (hde),
		.vde         (vde),
		.vblank_end  (vblank_end),
		.vsize       (vsize)
	);

	screen_monitor u_mon (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.vblank_end (vblank_end),
		.hsize      (line.hsize),
		.vsize      (vsize),
		.res        (vid.res),
		.crop       (crop),
		.scr        (scr),
		.scr_flg    (scr_flg)
	);

endmodule

//--- testbench/crop_assert.sv
// Concurrent checks on the crop top level
// Bound into every video_crop_top instance
`timescale 1ns/100ps

module crop_assert import crop_pkg::*; (
	input logic         clk_sys,
	input logic         reset,
	input logic         vblank_end,
	input logic         hde,
	input screen_info_t scr,
	input logic [6:0]   scr_flg
);

	// Mode counter moves only right after the end of vertical blank
	flg_after_vblank_end: assert property (
		@(posedge clk_sys) disable iff (reset)
		$changed(scr_flg) |-> $past(vblank_end)
	) else $error("scr_flg changed without a vblank_end on the clock before");

	reset_values: assert property (
		@(posedge clk_sys) reset |-> (scr == '0 && scr_flg == 7'd0 && !hde)
	) else $error("Outputs not cleared while reset is high");

	vblank_end_pulse: assert property (
		@(posedge clk_sys) disable iff (reset)
		vblank_end |=> !vblank_end
	) else $error("vblank_end held for more than one clock");

endmodule

bind video_crop_top crop_assert u_assert (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.vblank_end (vblank_end),  // Internal strobe from u_frame
	.hde        (hde),
	.scr        (scr),
	.scr_flg    (scr_flg)
);

//--- testbench/tb_video_crop.sv
// Testbench for the display crop top level
// Builds progressive frames from a geometry table and replays a table of key events
`timescale 1ns/100ps
`include "crop_defs.svh"

module tb_video_crop import crop_pkg::*; ();

	localparam int N_GEOMS    = 4;
	localparam int N_KEYS     = 21;
	localparam int GEOM_REPS  = 3;   // Frames per geometry row
	localparam int MAX_GAP    = 10;

	typedef struct packed {
		logic [11:0] len;    // Clocks per line
		logic [11:0] width;  // Active clocks per line
		logic [11:0] hsw;    // hsync clocks at line start
		logic [11:0] hact;   // First active clock of the line
		logic [11:0] lines;  // Active lines
		logic [11:0] vsl;    // vsync lines
		logic [11:0] vbl;    // Blank lines, sync included
		logic [1:0]  res;
	} geom_t;

	typedef struct packed {
		logic [7:0] data;
		logic [1:0] kind;
		logic       toggle;   // Level flips with this event
		logic       chk_hde;  // Mid-line hde count compared with zero crop
		crop_t      crop;     // Expected edges afterwards
	} key_row_t;

	geom_t geom_tab [0:N_GEOMS-1] = '{
		'{12'd64, 12'd40, 12'd4, 12'd16, 12'd12, 12'd2, 12'd6, 2'd0},
		'{12'd64, 12'd40, 12'd4, 12'd16, 12'd12, 12'd2, 12'd6, 2'd1},  // res only
		'{12'd80, 12'd48, 12'd6, 12'd20, 12'd16, 12'd3, 12'd7, 2'd1},
		'{12'd72, 12'd44, 12'd5, 12'd18, 12'd12, 12'd2, 12'd6, 2'd2}
	};

	// Edges in the order top, bottom, left, right
	key_row_t key_tab [0:N_KEYS-1] = '{
		'{`KEY_LEFT,     2'd3, 1'b1, 1'b1, '{12'd0, 12'd0,    12'd4,    12'd0}},
		'{`KEY_UP,       2'd3, 1'b1, 1'b0, '{12'd1, 12'd0,    12'd4,    12'd0}},
		'{`KEY_UP,       2'd3, 1'b1, 1'b0, '{12'd2, 12'd0,    12'd4,    12'd0}},
		'{`KEY_DOWN,     2'd3, 1'b1, 1'b0, '{12'd1, 12'd0,    12'd4,    12'd0}},
		'{`KEY_ALT_L,    2'd3, 1'b1, 1'b0, '{12'd1, 12'd0,    12'd4,    12'd0}},
		'{`KEY_UP,       2'd3, 1'b1, 1'b0, '{12'd1, 12'd1,    12'd4,    12'd0}},
		'{`KEY_LEFT,     2'd3, 1'b1, 1'b0, '{12'd1, 12'd1,    12'd4,    12'd4}},
		'{`KEY_RIGHT,    2'd3, 1'b1, 1'b0, '{12'd1, 12'd1,    12'd4,    12'd0}},
		'{`KEY_DOWN,     2'd3, 1'b1, 1'b1, '{12'd1, 12'd0,    12'd4,    12'd0}},
		'{`KEY_DOWN,     2'd3, 1'b1, 1'b0, '{12'd1, 12'hfff, 12'd4,    12'd0}},
		'{`KEY_ALT_L_UP, 2'd3, 1'b1, 1'b0, '{12'd1, 12'hfff, 12'd4,    12'd0}},
		'{`KEY_RIGHT,    2'd3, 1'b1, 1'b0, '{12'd1, 12'hfff, 12'd0,    12'd0}},
		'{`KEY_RIGHT,    2'd3, 1'b1, 1'b0, '{12'd1, 12'hfff, 12'hffc, 12'd0}},
		'{`KEY_LEFT,     2'd1, 1'b1, 1'b0, '{12'd1, 12'hfff, 12'hffc, 12'd0}},
		'{`KEY_UP,       2'd3, 1'b0, 1'b0, '{12'd1, 12'hfff, 12'hffc, 12'd0}},
		'{`KEY_ALT_R,    2'd3, 1'b1, 1'b0, '{12'd1, 12'hfff, 12'hffc, 12'd0}},
		'{`KEY_LEFT,     2'd3, 1'b1, 1'b0, '{12'd1, 12'hfff, 12'hffc, 12'd4}},
		'{`KEY_ALT_R_UP, 2'd3, 1'b1, 1'b0, '{12'd1, 12'hfff, 12'hffc, 12'd4}},
		'{8'h20,         2'd3, 1'b1, 1'b0, '{12'd1, 12'hfff, 12'hffc, 12'd4}},
		'{`KEY_BKSP,     2'd3, 1'b1, 1'b0, '{12'd0, 12'd0,    12'd0,    12'd0}},
		'{`KEY_LEFT,     2'd3, 1'b1, 1'b1, '{12'd0, 12'd0,    12'd4,    12'd0}}
	};

	logic         clk_sys;
	logic         reset;
	kbd_event_t   kbd;
	video_in_t    vid;
	logic         hde;
	logic         vde;
	screen_info_t scr;
	logic [6:0]   scr_flg;

	int          errors;
	int          checks;
	int          cycles;
	int          hde_cnt;     // hde clocks on the mid-screen line
	int          hde_base;
	logic [11:0] snap_hsize;  // Reference copy of the last snapshot
	logic [11:0] snap_vsize;
	logic [1:0]  snap_res;
	logic [11:0] prev_lines;  // Active lines of the frame before
	logic [6:0]  exp_flg;

	video_crop_top dut (
		.clk_sys (clk_sys),
		.reset   (reset),
		.kbd     (kbd),
		.vid     (vid),
		.hde     (hde),
		.vde     (vde),
		.scr     (scr),
		.scr_flg (scr_flg)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	function automatic int frame_clocks(input geom_t g);
		return int'(g.len) * (int'(g.vbl) + int'(g.lines));
	endfunction

	task automatic compare_value(input string name, input logic [79:0] got,
		input logic [79:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic idle_clocks(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// One progressive frame with the blank lines before the active area
	task automatic run_frame(input geom_t g);
		int ln;
		int p;
		int mid;
		mid = g.vbl + g.lines / 2;
		for (ln = 0; ln < g.vbl + g.lines; ln++) begin
			if (ln == mid) hde_cnt = 0;
			for (p = 0; p < g.len; p++) begin
				@(negedge clk_sys);
				if (ln == mid && hde) hde_cnt++;
				vid.hs_n   = (p >= g.hsw);
				vid.hblank = (p < g.hact) || (p >= g.hact + g.width);
				vid.vblank = (ln < g.vbl);
				vid.vs_n   = !(ln >= 2 && ln < 2 + g.vsl);  // Sync after two blank lines
				vid.res    = g.res;
			end
		end
	endtask

	task automatic send_key(input key_row_t k);
		@(negedge clk_sys);
		kbd.data = k.data;
		kbd.kind = k.kind;
		if (k.toggle) kbd.level = ~kbd.level;
	endtask

	// Snapshot holds this frame's width and the previous frame's height
	task automatic check_frame(input geom_t g, input crop_t exp_crop);
		if (g.width != snap_hsize || prev_lines != snap_vsize || g.res != snap_res)
			exp_flg++;
		snap_hsize = g.width;
		snap_vsize = prev_lines;
		snap_res   = g.res;
		prev_lines = g.lines;
		compare_value("scr.hsize", scr.hsize, snap_hsize);
		compare_value("scr.vsize", scr.vsize, snap_vsize);
		compare_value("scr.res", scr.res, snap_res);
		compare_value("scr.crop", scr.crop, exp_crop);
		compare_value("scr_flg", scr_flg, exp_flg);
	endtask

	initial begin : watchdog
		int k;
		int limit;
		limit = 2000;
		for (k = 0; k < N_GEOMS; k++)
			limit += GEOM_REPS * (frame_clocks(geom_tab[k]) + MAX_GAP);
		limit += (2 * N_KEYS + 1) * (frame_clocks(geom_tab[0]) + MAX_GAP);
		cycles = 0;
		while (cycles < limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: no end of test after %0d clocks", cycles);
		$display("TEST FAIL");
		$finish;
	end

	initial begin : main
		int r;
		int f;
		void'($urandom(32'hfc6f_a84a));
		errors     = 0;
		checks     = 0;
		hde_cnt    = 0;
		snap_hsize = '0;
		snap_vsize = '0;
		snap_res   = '0;
		prev_lines = '0;
		exp_flg    = '0;
		reset      = 1'b1;
		kbd        = '0;
		vid        = '{hs_n: 1'b1, vs_n: 1'b1, hblank: 1'b1, vblank: 1'b0, res: 2'd0};
		repeat (2) @(negedge clk_sys);
		compare_value("scr", scr, '0);
		compare_value("scr_flg", scr_flg, '0);
		compare_value("hde", hde, '0);
		compare_value("vde", vde, 1'b1);  // No vertical blank flag before any frame
		reset = 1'b0;

		for (r = 0; r < N_GEOMS; r++) begin
			for (f = 0; f < GEOM_REPS; f++) begin
				run_frame(geom_tab[r]);
				check_frame(geom_tab[r], '0);
				idle_clocks(2 + $urandom % 8);
			end
		end

		// Reference line width with all edges at zero
		run_frame(geom_tab[0]);
		check_frame(geom_tab[0], '0);
		hde_base = hde_cnt;
		compare_value("hde count", hde_base, geom_tab[0].width);

		for (r = 0; r < N_KEYS; r++) begin
			send_key(key_tab[r]);
			idle_clocks(2 + $urandom % 8);
			run_frame(geom_tab[0]);
			check_frame(geom_tab[0], key_tab[r].crop);
			if (key_tab[r].chk_hde)
				compare_value("hde count", hde_cnt, hde_base - `H_STEP);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- project.f
+incdir+verilog
verilog/crop_pkg.sv
verilog/kbd_crop_ctrl.sv
verilog/line_timing.sv
verilog/frame_timing.sv
verilog/screen_monitor.sv
verilog/video_crop_top.sv
testbench/crop_assert.sv
testbench/tb_video_crop.sv
